/* Bender.yml */
package:
  name: host_link_ctrl

sources:
  - files:
      - rtl/host_link_pkg.sv
      - rtl/cmd_sequencer.sv
      - rtl/apb_access.sv
      - rtl/rsp_framer.sv
      - rtl/host_link_ctrl.sv
  - target: test
    files:
      - tb/host_link_properties.sv
      - tb/tb_host_link_ctrl.sv

/* host_link_ctrl.f */
rtl/host_link_pkg.sv
rtl/cmd_sequencer.sv
rtl/apb_access.sv
rtl/rsp_framer.sv
rtl/host_link_ctrl.sv
tb/host_link_properties.sv
tb/tb_host_link_ctrl.sv

/* rtl/apb_access.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_access (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 acc_start,
  input  logic                                 acc_write,
  input  logic [host_link_pkg::REG_ADDR_W-1:0] acc_addr,
  input  logic [host_link_pkg::REG_DATA_W-1:0] acc_wdata,
  input  logic [host_link_pkg::REG_DATA_W-1:0] prdata,
  input  logic                                 pslverr,
  output logic                                 psel,
  output logic                                 penable,
  output logic                                 pwrite,
  output logic [host_link_pkg::REG_ADDR_W-1:0] paddr,
  output logic [host_link_pkg::REG_DATA_W-1:0] pwdata,
  output logic                                 acc_done,
  output logic [host_link_pkg::REG_DATA_W-1:0] acc_rdata,
  output logic                                 acc_err
);

  // Single bus cycle, select and enable together, zero wait states
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      psel     <= 1'b0;
      penable  <= 1'b0;
      pwrite   <= 1'b0;
      paddr    <= '0;
      pwdata   <= '0;
      acc_done <= 1'b0;
    end else begin
      acc_done <= psel;  // Cycle after the bus cycle
      if (acc_start) begin
        psel    <= 1'b1;
        penable <= 1'b1;
        pwrite  <= acc_write;
        paddr   <= acc_addr;
        pwdata  <= acc_write ? acc_wdata : '0;
      end else begin
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
      end
    end
  end

  // Slave answer is valid during the bus cycle itself
  always_ff @(posedge clk) begin
    if (psel) begin
      acc_err <= pslverr;
      if (!pwrite)
        acc_rdata <= prdata;
    end
  end

endmodule

`default_nettype wire

/* rtl/cmd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer #(
  parameter int unsigned RX_FAW = 3
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  host_link_pkg::byte_t [2**RX_FAW-1:0] rx_array,
  input  logic                                 rx_done,
  input  logic [RX_FAW-1:0]                    rx_level,
  input  logic [1:0]                           fatal_errors,
  output logic                                 rx_fifo_flush,
  output logic                                 ready,
  output logic                                 acc_start,
  output logic                                 acc_write,
  output logic [host_link_pkg::REG_ADDR_W-1:0] acc_addr,
  output logic [host_link_pkg::REG_DATA_W-1:0] acc_wdata,
  input  logic                                 acc_done,
  output logic                                 rsp_start,
  output host_link_pkg::rsp_kind_t             rsp_kind,
  output logic [host_link_pkg::REG_ADDR_W-1:0] rsp_addr,
  output host_link_pkg::byte_t                 rsp_err_byte,
  input  logic                                 rsp_done
);
  import host_link_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE      = 3'd0,
    S_CMD       = 3'd1,
    S_ADDR_WAIT = 3'd2,
    S_ADDR      = 3'd3,
    S_DATA_WAIT = 3'd4,
    S_ACC       = 3'd5,
    S_RSP       = 3'd6
  } state_t;

  localparam logic [RX_FAW-1:0] RX_LVL_MAX = '1;  // Depth minus one

  state_t                state;
  cmd_t                  cmd;
  logic                  cmd_ok;
  logic                  cmd_err;
  logic [1:0]            fatal_r;
  logic                  data_ready;
  logic [REG_ADDR_W-1:0] addr;
  logic [REG_DATA_W-1:0] wdata;
  logic [REG_DATA_W-1:0] wdata_next;

  assign ready        = (rx_level < RX_LVL_MAX);
  assign acc_write    = (cmd == CMD_REG_WRITE);
  assign acc_addr     = addr;
  assign acc_wdata    = wdata;
  assign rsp_addr     = addr;
  assign rsp_err_byte = {5'b0, fatal_r, cmd_err};
  assign data_ready   = (rx_level == RX_FAW'(REG_DATA_BYTES));

  always_comb begin
    case (cmd_t'(rx_array[0][3:0]))
      CMD_REG_READ:  cmd_ok = 1'b1;
      CMD_REG_WRITE: cmd_ok = 1'b1;
      CMD_TX_MSG:    cmd_ok = 1'b0;  // Downlink message path removed
      default:       cmd_ok = 1'b0;
    endcase
  end

  // Data bytes arrive MSB first, entry 0 is the oldest
  always_comb begin
    wdata_next = '0;
    for (int i = 0; i < REG_DATA_BYTES; i++) begin
      wdata_next[REG_DATA_W-1-8*i -: 8] = rx_array[i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= S_IDLE;
      cmd           <= '0;
      cmd_err       <= 1'b0;
      fatal_r       <= '0;
      rx_fifo_flush <= 1'b0;
      acc_start     <= 1'b0;
      rsp_start     <= 1'b0;
      rsp_kind      <= RSP_KIND_ERR;
    end else begin
      rx_fifo_flush <= 1'b0;
      acc_start     <= 1'b0;
      rsp_start     <= 1'b0;
      case (state)
        S_IDLE: begin
          if (rx_done)
            state <= S_CMD;
        end
        S_CMD: begin
          cmd           <= rx_array[0][3:0];
          cmd_err       <= !cmd_ok;
          fatal_r       <= '0;
          rx_fifo_flush <= 1'b1;  // Drop the command byte
          if (cmd_ok) begin
            state <= S_ADDR_WAIT;
          end else begin
            rsp_kind  <= RSP_KIND_ERR;
            rsp_start <= 1'b1;
            state     <= S_RSP;
          end
        end
        S_ADDR_WAIT: begin
          if (fatal_errors != '0) begin
            // UART broke while the address byte was due
            fatal_r   <= fatal_errors;
            rsp_kind  <= RSP_KIND_ERR;
            rsp_start <= 1'b1;
            state     <= S_RSP;
          end else if (rx_done) begin
            state <= S_ADDR;
          end
        end
        S_ADDR: begin
          rx_fifo_flush <= 1'b1;
          if (acc_write) begin
            state <= S_DATA_WAIT;
          end else begin
            acc_start <= 1'b1;  // Read goes straight to the bus
            state     <= S_ACC;
          end
        end
        S_DATA_WAIT: begin
          if (data_ready) begin
            rx_fifo_flush <= 1'b1;
            acc_start     <= 1'b1;
            state         <= S_ACC;
          end
        end
        S_ACC: begin
          if (acc_done) begin
            rsp_kind  <= acc_write ? RSP_KIND_WRITE : RSP_KIND_READ;
            rsp_start <= 1'b1;
            state     <= S_RSP;
          end
        end
        S_RSP: begin
          if (rsp_done)
            state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_ADDR)
      addr <= rx_array[0];
    if (state == S_DATA_WAIT && data_ready)
      wdata <= wdata_next;
  end

endmodule

`default_nettype wire

/* rtl/host_link_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module host_link_ctrl #(
  parameter int unsigned RX_FAW = 3,
  parameter int unsigned TX_FAW = 3
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Receive FIFO
  input  host_link_pkg::byte_t [2**RX_FAW-1:0] rx_array,
  input  logic                                 rx_done,
  input  logic [RX_FAW-1:0]                    rx_level,
  input  logic [1:0]                           fatal_errors,
  output logic                                 rx_fifo_flush,
  output logic                                 ready,
  // Transmit FIFO
  input  logic [TX_FAW-1:0]                    tx_level,
  input  logic                                 tx_grant,
  output logic                                 tx_req,
  output logic                                 tx_wr,
  output host_link_pkg::byte_t                 tx_wdata,
  // Register bus
  output logic                                 psel,
  output logic                                 penable,
  output logic                                 pwrite,
  output logic [host_link_pkg::REG_ADDR_W-1:0] paddr,
  output logic [host_link_pkg::REG_DATA_W-1:0] pwdata,
  input  logic [host_link_pkg::REG_DATA_W-1:0] prdata,
  input  logic                                 pslverr
);
  import host_link_pkg::*;

  logic                  acc_start;
  logic                  acc_write;
  logic [REG_ADDR_W-1:0] acc_addr;
  logic [REG_DATA_W-1:0] acc_wdata;
  logic                  acc_done;
  logic [REG_DATA_W-1:0] acc_rdata;
  logic                  acc_err;
  logic                  rsp_start;
  rsp_kind_t             rsp_kind;
  logic [REG_ADDR_W-1:0] rsp_addr;
  byte_t                 rsp_err_byte;
  logic                  rsp_done;

  cmd_sequencer #(
    .RX_FAW (RX_FAW)
  ) i_cmd_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_array      (rx_array),
    .rx_done       (rx_done),
    .rx_level      (rx_level),
    .fatal_errors  (fatal_errors),
    .rx_fifo_flush (rx_fifo_flush),
    .ready         (ready),
    .acc_start     (acc_start),
    .acc_write     (acc_write),
    .acc_addr      (acc_addr),
    .acc_wdata     (acc_wdata),
    .acc_done      (acc_done),
    .rsp_start     (rsp_start),
    .rsp_kind      (rsp_kind),
    .rsp_addr      (rsp_addr),
    .rsp_err_byte  (rsp_err_byte),
    .rsp_done      (rsp_done)
  );

  apb_access i_apb_access (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_start (acc_start),
    .acc_write (acc_write),
    .acc_addr  (acc_addr),
    .acc_wdata (acc_wdata),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .acc_done  (acc_done),
    .acc_rdata (acc_rdata),
    .acc_err   (acc_err)
  );

  rsp_framer #(
    .TX_FAW (TX_FAW)
  ) i_rsp_framer (
    .clk          (clk),
    .rst_n        (rst_n),
    .rsp_start    (rsp_start),
    .rsp_kind     (rsp_kind),
    .rsp_addr     (rsp_addr),
    .rsp_err_byte (rsp_err_byte),
    .acc_rdata    (acc_rdata),
    .acc_err      (acc_err),
    .tx_level     (tx_level),
    .tx_grant     (tx_grant),
    .tx_req       (tx_req),
    .tx_wr        (tx_wr),
    .tx_wdata     (tx_wdata),
    .rsp_done     (rsp_done)
  );

endmodule

`default_nettype wire

/* rtl/host_link_pkg.sv */
`default_nettype none

package host_link_pkg;

  // One UART byte
  typedef logic [7:0] byte_t;

  // Command code, low nibble of the first command byte
  typedef logic [3:0] cmd_t;

  localparam cmd_t CMD_REG_READ  = 4'd1;
  localparam cmd_t CMD_REG_WRITE = 4'd2;
  localparam cmd_t CMD_TX_MSG    = 4'd3;  // Message path not served here

  // First byte of each response frame
  localparam byte_t RSP_CMD_ERR   = 8'hE0;
  localparam byte_t RSP_WRITE_RES = 8'hA2;
  localparam byte_t RSP_READ_RES  = 8'hA1;

  // Which response frame the framer sends
  typedef enum logic [1:0] {
    RSP_KIND_ERR   = 2'd0,
    RSP_KIND_WRITE = 2'd1,
    RSP_KIND_READ  = 2'd2
  } rsp_kind_t;

  // Frame lengths in bytes, code byte included
  localparam int unsigned RSP_LEN_ERR   = 2;
  localparam int unsigned RSP_LEN_WRITE = 3;
  localparam int unsigned RSP_LEN_READ  = 5;

  // Register bus geometry
  localparam int unsigned REG_ADDR_W     = 8;
  localparam int unsigned REG_DATA_W     = 32;
  localparam int unsigned REG_DATA_BYTES = REG_DATA_W / 8;

endpackage

`default_nettype wire

/* rtl/rsp_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module rsp_framer #(
  parameter int unsigned TX_FAW = 3
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 rsp_start,
  input  host_link_pkg::rsp_kind_t             rsp_kind,
  input  logic [host_link_pkg::REG_ADDR_W-1:0] rsp_addr,
  input  host_link_pkg::byte_t                 rsp_err_byte,
  input  logic [host_link_pkg::REG_DATA_W-1:0] acc_rdata,
  input  logic                                 acc_err,
  input  logic [TX_FAW-1:0]                    tx_level,
  input  logic                                 tx_grant,
  output logic                                 tx_req,
  output logic                                 tx_wr,
  output host_link_pkg::byte_t                 tx_wdata,
  output logic                                 rsp_done
);
  import host_link_pkg::*;

  rsp_kind_t         kind_r;
  logic [TX_FAW-1:0] cnt;  // Bytes written so far
  logic [TX_FAW-1:0] frame_len;
  byte_t             frame_byte;
  logic              wr_now;
  logic              frame_end;

  // Length and content of the frame, byte picked by cnt
  always_comb begin
    frame_byte = '0;
    case (kind_r)
      RSP_KIND_WRITE: begin
        frame_len = TX_FAW'(RSP_LEN_WRITE);
        if (cnt == '0)
          frame_byte = RSP_WRITE_RES;
        else if (cnt == TX_FAW'(1))
          frame_byte = byte_t'(rsp_addr);
        else
          frame_byte = {7'b0, acc_err};  // Slave error status
      end
      RSP_KIND_READ: begin
        frame_len = TX_FAW'(RSP_LEN_READ);
        if (cnt == '0)
          frame_byte = RSP_READ_RES;
        else if (cnt <= TX_FAW'(REG_DATA_BYTES))
          frame_byte = acc_rdata[REG_DATA_W - 8 * cnt +: 8];  // MSB first
      end
      default: begin
        frame_len  = TX_FAW'(RSP_LEN_ERR);
        frame_byte = (cnt == '0) ? RSP_CMD_ERR : rsp_err_byte;
      end
    endcase
  end

  // One byte per level step, never back to back
  assign wr_now = tx_req && tx_grant && !tx_wr && (tx_level == cnt) && (cnt < frame_len);

  assign frame_end = tx_req && (cnt == frame_len) && (tx_level == frame_len);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      kind_r   <= RSP_KIND_ERR;
      cnt      <= '0;
      tx_req   <= 1'b0;
      tx_wr    <= 1'b0;
      rsp_done <= 1'b0;
    end else begin
      rsp_done <= 1'b0;
      tx_wr    <= wr_now;
      if (rsp_start) begin
        kind_r <= rsp_kind;
        cnt    <= '0;
        tx_req <= 1'b1;  // Held until the whole frame is in the FIFO
      end else if (frame_end) begin
        tx_req   <= 1'b0;
        rsp_done <= 1'b1;
      end else if (wr_now) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_now)
      tx_wdata <= frame_byte;
  end

endmodule

`default_nettype wire

/* tb/host_link_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module host_link_properties (
  input logic clk,
  input logic rst_n,
  input logic psel,
  input logic penable,
  input logic tx_req,
  input logic tx_wr,
  input logic rx_fifo_flush
);

  int unsigned fail_cnt = 0;  // Summed into the result line

  // Single-cycle bus access, select and enable together
  a_sel_with_enable: assert property (@(posedge clk) disable iff (!rst_n) psel == penable)
    else begin
      $error("psel and penable differ");
      fail_cnt++;
    end

  a_sel_single: assert property (@(posedge clk) disable iff (!rst_n) psel |=> !psel)
    else begin
      $error("psel high for two cycles in a row");
      fail_cnt++;
    end

  a_wr_in_req: assert property (@(posedge clk) disable iff (!rst_n) tx_wr |-> tx_req)
    else begin
      $error("tx_wr without tx_req");
      fail_cnt++;
    end

  a_wr_spaced: assert property (@(posedge clk) disable iff (!rst_n) tx_wr |=> !tx_wr)
    else begin
      $error("tx_wr in two consecutive cycles");
      fail_cnt++;
    end

  a_flush_single: assert property (@(posedge clk) disable iff (!rst_n)
                                   rx_fifo_flush |=> !rx_fifo_flush)
    else begin
      $error("rx_fifo_flush high for two cycles in a row");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* tb/tb_host_link_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_host_link_ctrl;
  import host_link_pkg::*;

  typedef logic [7:0] bytes_t [$];

  localparam int N_RW       = 6;   // Write/read pairs at normal addresses
  localparam int N_ERR_ADDR = 2;   // Addresses in the error range
  localparam int N_BP       = 6;   // Pairs under random grant delay
  localparam int N_TRANS    = 2 * N_RW + 2 * N_ERR_ADDR + 3 + 3 + 2 * N_BP + 2;
  localparam int RUN_LIMIT  = 300 * N_TRANS;
  localparam int FRAME_WAIT = 300;
  localparam int BYTE_GAP   = 6;   // Cycles between received bytes

  logic                     clk;
  logic                     rst_n;
  byte_t [7:0]              rx_array;
  logic                     rx_done;
  logic [2:0]               rx_level;
  logic [1:0]               fatal_errors;
  logic                     rx_fifo_flush;
  logic                     ready;
  logic [2:0]               tx_level;
  logic                     tx_grant;
  logic                     tx_req;
  logic                     tx_wr;
  byte_t                    tx_wdata;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [7:0]               paddr;
  logic [31:0]              pwdata;
  logic [31:0]              prdata;
  logic                     pslverr;

  logic [31:0] mem [256];    // Register slave storage
  byte_t       rx_pending[$];
  byte_t       captured[$];
  byte_t       last_frame[$];
  int unsigned frame_cnt = 0;
  int unsigned flush_cnt = 0;
  int unsigned acc_cnt = 0;
  int unsigned grant_delay = 0;
  logic [7:0]  last_paddr;
  logic        last_pwrite;
  logic [31:0] last_pwdata;
  logic        saw_full = 1'b0;
  int unsigned check_cnt = 0;
  int unsigned mismatch_cnt = 0;
  int unsigned other_cnt = 0;

  host_link_ctrl #(
    .RX_FAW (3),
    .TX_FAW (3)
  ) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx_array      (rx_array),
    .rx_done       (rx_done),
    .rx_level      (rx_level),
    .fatal_errors  (fatal_errors),
    .rx_fifo_flush (rx_fifo_flush),
    .ready         (ready),
    .tx_level      (tx_level),
    .tx_grant      (tx_grant),
    .tx_req        (tx_req),
    .tx_wr         (tx_wr),
    .tx_wdata      (tx_wdata),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pslverr       (pslverr)
  );

  bind host_link_ctrl host_link_properties i_host_link_properties (
    .clk           (clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .tx_req        (tx_req),
    .tx_wr         (tx_wr),
    .rx_fifo_flush (rx_fifo_flush)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // FIFO and slave models sample at negedge and drive 1 ns after posedge
  initial begin
    logic       flush_s;
    logic       wr_s;
    logic       req_prev;
    logic       fell;
    logic       grant_next;
    logic [7:0] a;
    int         gap;
    int         gcnt;
    rx_array = '0;
    rx_done  = 1'b0;
    rx_level = '0;
    tx_level = '0;
    tx_grant = 1'b0;
    prdata   = '0;
    pslverr  = 1'b0;
    req_prev = 1'b0;
    gap      = BYTE_GAP;
    gcnt     = 0;
    for (int i = 0; i < 256; i++) begin
      a = i[7:0];
      mem[i] = {a, ~a, a ^ 8'h5A, a + 8'h3C};
    end
    forever begin
      @(negedge clk);
      flush_s = rx_fifo_flush;
      if (rx_fifo_flush)
        flush_cnt++;
      if (rst_n)
        check_value("ready", ready, rx_level < 3'd7);
      if (rx_level == 3'd7)
        saw_full = 1'b1;
      if (psel) begin
        acc_cnt++;
        last_paddr  = paddr;
        last_pwrite = pwrite;
        last_pwdata = pwdata;
        if (pwrite && paddr < 8'hF0)
          mem[paddr] = pwdata;
      end
      wr_s = tx_wr;
      if (tx_wr)
        captured.push_back(tx_wdata);
      fell = req_prev && !tx_req;
      if (fell) begin
        last_frame = captured;
        captured.delete();
        frame_cnt++;
      end
      req_prev   = tx_req;
      grant_next = tx_grant;
      if (!tx_req) begin
        gcnt       = 0;
        grant_next = 1'b0;
      end else if (!tx_grant) begin
        if (gcnt >= grant_delay)
          grant_next = 1'b1;
        else
          gcnt++;
      end
      @(posedge clk);
      #1;
      rx_done = 1'b0;
      if (flush_s) begin
        rx_level = '0;
        rx_array = '0;
      end else if (rx_pending.size() > 0 && gap >= BYTE_GAP) begin
        if (rx_level == 3'd7) begin
          $display("Receive FIFO overflow, a byte was dropped");
          other_cnt++;
          void'(rx_pending.pop_front());
        end else begin
          rx_array[rx_level] = rx_pending.pop_front();
          rx_level++;
          rx_done = 1'b1;
          gap     = 0;
        end
      end
      if (gap < BYTE_GAP)
        gap++;
      if (wr_s)
        tx_level++;
      if (fell)
        tx_level = '0;  // Frame drained by the UART
      tx_grant = grant_next;
      // Zero wait state slave with errors from 0xF0 up
      prdata  = (psel && !pwrite && paddr < 8'hF0) ? mem[paddr] : '0;
      pslverr = psel && (paddr >= 8'hF0);
    end
  end

  task automatic queue_rx_byte(input byte_t b);
    rx_pending.push_back(b);
  endtask

  task automatic wait_frame(input int unsigned since, input string what);
    int n;
    n = 0;
    while (frame_cnt == since && n < FRAME_WAIT) begin
      @(posedge clk);
      n++;
    end
    if (frame_cnt == since) begin
      $display("No response frame for %s within %0d cycles", what, FRAME_WAIT);
      other_cnt++;
    end
  endtask

  task automatic wait_flush(input int unsigned since);
    int n;
    n = 0;
    while (flush_cnt == since && n < FRAME_WAIT) begin
      @(posedge clk);
      n++;
    end
    if (flush_cnt == since) begin
      $display("Command byte was never flushed from the receive FIFO");
      other_cnt++;
    end
  endtask

  task automatic wait_rx_drained();
    int n;
    n = 0;
    while (rx_pending.size() > 0 && n < FRAME_WAIT) begin
      @(posedge clk);
      n++;
    end
    if (rx_pending.size() > 0) begin
      $display("Receive FIFO model did not take all queued bytes");
      other_cnt++;
    end
  endtask

  task automatic compare_frame(input string what, input bytes_t exp);
    if (last_frame.size() != exp.size()) begin
      $display("Wrong frame length for %s: %0d bytes, expected %0d",
               what, last_frame.size(), exp.size());
      other_cnt++;
    end else begin
      foreach (exp[i])
        check_value($sformatf("tx_wdata %s byte %0d", what, i), last_frame[i], exp[i]);
    end
  endtask

  // Strobes and bus controls are all low once reset is released
  task automatic idle_after_reset();
    @(negedge clk);
    check_value("tx_req", tx_req, 1'b0);
    check_value("tx_wr", tx_wr, 1'b0);
    check_value("rx_fifo_flush", rx_fifo_flush, 1'b0);
    check_value("psel", psel, 1'b0);
    check_value("penable", penable, 1'b0);
    check_value("pwrite", pwrite, 1'b0);
  endtask

  task automatic write_register(input logic [7:0] addr, input logic [31:0] data,
                                input logic exp_err);
    int unsigned f0;
    int unsigned acc0;
    bytes_t      exp;
    f0   = frame_cnt;
    acc0 = acc_cnt;
    queue_rx_byte(8'h02);
    queue_rx_byte(addr);
    for (int i = 3; i >= 0; i--)
      queue_rx_byte(data[8*i +: 8]);  // MSB first
    wait_frame(f0, "register write");
    exp = '{8'hA2, addr, {7'b0, exp_err}};
    compare_frame("write", exp);
    check_value("bus accesses per write", acc_cnt - acc0, 1);
    check_value("paddr", last_paddr, addr);
    check_value("pwrite", last_pwrite, 1'b1);
    check_value("pwdata", last_pwdata, data);
    if (!exp_err)
      check_value($sformatf("slave word 0x%0h", addr), mem[addr], data);
  endtask

  task automatic read_register(input logic [7:0] addr, input logic [31:0] exp_data);
    int unsigned f0;
    int unsigned acc0;
    bytes_t      exp;
    f0   = frame_cnt;
    acc0 = acc_cnt;
    queue_rx_byte(8'h01);
    queue_rx_byte(addr);
    wait_frame(f0, "register read");
    exp = '{8'hA1, exp_data[31:24], exp_data[23:16], exp_data[15:8], exp_data[7:0]};
    compare_frame("read", exp);
    check_value("bus accesses per read", acc_cnt - acc0, 1);
    check_value("paddr", last_paddr, addr);
    check_value("pwrite", last_pwrite, 1'b0);
  endtask

  task automatic write_then_read_back();
    logic [7:0]  addr;
    logic [31:0] data;
    for (int i = 0; i < N_RW; i++) begin
      addr = 8'($urandom % 240);
      data = $urandom;
      write_register(addr, data, 1'b0);
      read_register(addr, data);
    end
  endtask

  task automatic slave_error_access();
    logic [7:0] addr;
    for (int i = 0; i < N_ERR_ADDR; i++) begin
      addr = (i == 0) ? 8'hF0 : 8'hF0 + 8'($urandom % 16);
      write_register(addr, $urandom, 1'b1);
      read_register(addr, 32'h0);
    end
  endtask

  task automatic unknown_command();
    logic [3:0]  codes [3];
    int unsigned f0;
    int unsigned acc0;
    codes = '{4'h0, 4'h3, 4'hF};
    foreach (codes[i]) begin
      f0   = frame_cnt;
      acc0 = acc_cnt;
      queue_rx_byte({4'($urandom), codes[i]});  // Upper nibble is not decoded
      wait_frame(f0, $sformatf("command code 0x%0h", codes[i]));
      compare_frame("command error", '{8'hE0, 8'h01});
      check_value("bus accesses on unknown command", acc_cnt - acc0, 0);
    end
  endtask

  task automatic fatal_during_address();
    int unsigned f0;
    int unsigned acc0;
    for (int f = 1; f < 4; f++) begin
      f0   = frame_cnt;
      acc0 = acc_cnt;
      queue_rx_byte(8'h01);
      wait_flush(flush_cnt);
      #1 fatal_errors = 2'(f);
      wait_frame(f0, "fatal error");
      compare_frame("fatal error", '{8'hE0, {5'b0, 2'(f), 1'b0}});
      check_value("bus accesses on fatal error", acc_cnt - acc0, 0);
      #1 fatal_errors = 2'b00;
      @(posedge clk);
    end
  endtask

  task automatic back_pressure_and_ready();
    logic [7:0]  addr;
    logic [31:0] data;
    int unsigned f0;
    int unsigned acc0;
    for (int i = 0; i < N_BP; i++) begin
      grant_delay = $urandom % 41;
      addr = 8'($urandom % 240);
      data = $urandom;
      write_register(addr, data, 1'b0);
      read_register(addr, data);
    end
    // Fill the receive FIFO while a slow response holds the FSM
    grant_delay = 60;
    saw_full    = 1'b0;
    f0   = frame_cnt;
    acc0 = acc_cnt;
    queue_rx_byte(8'h0F);
    queue_rx_byte(8'h00);  // Becomes the oldest entry and decodes as unknown
    for (int i = 0; i < 5; i++)
      queue_rx_byte($urandom);
    wait_rx_drained();
    check_value("rx_level before last byte", rx_level, 6);
    check_value("ready at level 6", ready, 1'b1);
    wait_frame(f0, "unknown command under back-pressure");
    compare_frame("command error", '{8'hE0, 8'h01});
    check_value("full level seen early", saw_full, 1'b0);
    f0 = frame_cnt;
    queue_rx_byte($urandom);  // Level 7
    wait_frame(f0, "command from a full FIFO");
    compare_frame("command error", '{8'hE0, 8'h01});
    check_value("full level seen", saw_full, 1'b1);
    check_value("rx_level after flush", rx_level, 0);
    check_value("bus accesses while filling", acc_cnt - acc0, 0);
    grant_delay = 0;
  endtask

  initial begin
    int unsigned cycles;
    cycles = 0;
    while (cycles < RUN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", RUN_LIMIT);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int unsigned prop_fails;
    void'($urandom(32'h96ec));
    rst_n        = 1'b0;
    fatal_errors = 2'b00;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    idle_after_reset();
    repeat (4) @(posedge clk);
    write_then_read_back();
    slave_error_access();
    unknown_command();
    fatal_during_address();
    back_pressure_and_ready();
    repeat (4) @(posedge clk);
    prop_fails = i_dut.i_host_link_properties.fail_cnt;
    $display("Result: %0d checks, %0d mismatches, %0d other errors, %0d assertion failures",
             check_cnt, mismatch_cnt, other_cnt, prop_fails);
    if (mismatch_cnt + other_cnt + prop_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
